// File: hw/avmm_cmd_fifo.sv
// four-entry address and data command queue between controller and write master

`timescale 1ns/1ns

module avmm_cmd_fifo
  import avmm_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  // push side, never refused since the controller holds the credits
  input  logic                       cmd_push,
  input  logic [rcfg_addr_width-1:0] push_addr,
  input  logic [rcfg_data_width-1:0] push_data,
  // pop side, head entry shown while not empty
  input  logic                       cmd_pop,
  output logic                       cmd_valid,
  output logic [rcfg_addr_width-1:0] cmd_addr,
  output logic [rcfg_data_width-1:0] cmd_data
);

  // ========================================
  // storage
  // ========================================

  logic [rcfg_addr_width-1:0] addr_mem [cmd_fifo_depth];
  logic [rcfg_data_width-1:0] data_mem [cmd_fifo_depth];

  logic [cmd_ptr_width-1:0]   wr_ptr;
  logic [cmd_ptr_width-1:0]   rd_ptr;
  logic [cmd_count_width-1:0] count;

  // pop only counts against a real entry
  logic                       pop_ok;

  assign cmd_valid = (count != '0);
  assign pop_ok    = cmd_pop && cmd_valid;

  // head of queue straight from the array
  assign cmd_addr = addr_mem[rd_ptr];
  assign cmd_data = data_mem[rd_ptr];

  // write port, entry visible at the head one cycle later
  always_ff @(posedge clk) begin
    if (cmd_push) begin
      addr_mem[wr_ptr] <= push_addr;
      data_mem[wr_ptr] <= push_data;
    end
  end

  // ========================================
  // pointers and occupancy
  // ========================================

  // pointers wrap naturally at four entries
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (cmd_push) begin
        wr_ptr <= wr_ptr + cmd_ptr_width'(1);
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + cmd_ptr_width'(1);
      end
      // push and pop together keep the count
      case ({cmd_push, pop_ok})
        2'b10:   count <= count + cmd_count_width'(1);
        2'b01:   count <= count - cmd_count_width'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hw/avmm_pkg.sv
// reconfiguration bus widths, command queue depth and credit counter sizing

package avmm_pkg;

  // ========================================
  // reconfiguration bus
  // ========================================

  // word address into the transceiver register space
  localparam int rcfg_addr_width = 10;

  // write data per bus access
  localparam int rcfg_data_width = 8;

  // ========================================
  // command queue and credits
  // ========================================

  // queue entries, also the credits the controller owns after reset
  localparam int cmd_fifo_depth = 4;

  // read and write pointer width for the queue
  localparam int cmd_ptr_width = 2;

  // occupancy counter, counts 0 up to cmd_fifo_depth
  localparam int cmd_count_width = 3;

  // credit counter, also counts 0 up to cmd_fifo_depth
  localparam int credit_width = 3;

endpackage

// File: hw/avmm_write_master.sv
// reconfiguration bus write master with wait request hold and credit return

`timescale 1ns/1ns

module avmm_write_master
  import avmm_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  // head of the command queue
  input  logic                       cmd_valid,
  input  logic [rcfg_addr_width-1:0] cmd_addr,
  input  logic [rcfg_data_width-1:0] cmd_data,
  output logic                       cmd_pop,
  // transceiver reconfiguration port
  output logic [rcfg_addr_width-1:0] rcfg_address,
  output logic [rcfg_data_width-1:0] rcfg_writedata,
  output logic                       rcfg_write,
  input  logic                       rcfg_waitrequest,
  // one pulse per landed write, back to the controller
  output logic                       credit_return
);

  // ========================================
  // write FSM
  // ========================================

  typedef enum logic {
    st_idle,
    st_write
  } state_t;

  state_t state;

  // take the head whenever idle and the queue has something
  assign cmd_pop = (state == st_idle) && cmd_valid;

  // write strobe is the writing state itself
  assign rcfg_write = (state == st_write);

  // the write lands in the first cycle without wait request
  assign credit_return = rcfg_write && !rcfg_waitrequest;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (cmd_valid) begin
            state <= st_write;
          end
        end
        st_write: begin
          // stay put while the port stalls us
          if (!rcfg_waitrequest) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ========================================
  // bus payload
  // ========================================

  // loaded only on a pop, which only happens when idle
  // so address and data stay fixed for the whole write
  always_ff @(posedge clk) begin
    if (cmd_pop) begin
      rcfg_address   <= cmd_addr;
      rcfg_writedata <= cmd_data;
    end
  end

  // next write can pop in the cycle after completion
  // that gives one idle cycle between back to back writes

endmodule

// File: hw/txeq_ctrl.sv
// tx equalization controller with request latch, tap sequencer, credit counter and busy

`timescale 1ns/1ns

module txeq_ctrl
  import avmm_pkg::*;
  import txeq_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  // requests from the link training engine
  input  logic                       lt_start_rc,
  input  logic [main_tap_width-1:0]  main_rc,
  input  logic [post_tap_width-1:0]  post_rc,
  input  logic [pre_tap_width-1:0]   pre_rc,
  input  logic [tap_mask_width-1:0]  tap_to_upd,
  output logic                       rc_busy,
  // credit comes back from the write master once a write has landed
  input  logic                       credit_return,
  // push side of the command queue
  output logic                       cmd_push,
  output logic [rcfg_addr_width-1:0] cmd_addr,
  output logic [rcfg_data_width-1:0] cmd_data
);

  // ========================================
  // state
  // ========================================

  // tap values captured at the accepted start
  logic [main_tap_width-1:0]  main_q;
  logic [post_tap_width-1:0]  post_q;
  logic [pre_tap_width-1:0]   pre_q;

  // taps still waiting to be pushed
  logic [tap_mask_width-1:0]  pending_mask;

  // free slots in queue plus master
  logic [credit_width-1:0]    credit_cnt;

  logic                       start_ok;
  logic                       push_ok;

  // tap picked this cycle, one-hot in mask positions
  logic [tap_mask_width-1:0]  sel_bit;
  logic [rcfg_addr_width-1:0] sel_addr;
  logic [rcfg_data_width-1:0] sel_data;

  // busy while any tap is pending or any write is still in flight
  // full credits with nothing pending means every write has completed
  assign rc_busy = (pending_mask != '0) ||
                   (credit_cnt != credit_width'(cmd_fifo_depth));

  // a start is taken only when idle and at least one tap is selected
  assign start_ok = lt_start_rc && !rc_busy && (tap_to_upd != '0);

  // one push per cycle, only with a credit in hand
  assign push_ok = (pending_mask != '0) && (credit_cnt != '0);

  // ========================================
  // tap sequencer
  // ========================================

  // fixed order main, post, pre
  // values are zero-extended to the register width
  always_comb begin
    sel_bit  = '0;
    sel_addr = '0;
    sel_data = '0;
    if (pending_mask[main_tap_bit]) begin
      sel_bit[main_tap_bit] = 1'b1;
      sel_addr = main_tap_addr;
      sel_data = rcfg_data_width'(main_q);
    end else if (pending_mask[post_tap_bit]) begin
      sel_bit[post_tap_bit] = 1'b1;
      sel_addr = post_tap_addr;
      sel_data = rcfg_data_width'(post_q);
    end else if (pending_mask[pre_tap_bit]) begin
      sel_bit[pre_tap_bit] = 1'b1;
      sel_addr = pre_tap_addr;
      sel_data = rcfg_data_width'(pre_q);
    end
  end

  // request latch, tap values only change on an accepted start
  always_ff @(posedge clk) begin
    if (start_ok) begin
      main_q <= main_rc;
      post_q <= post_rc;
      pre_q  <= pre_rc;
    end
  end

  // pending mask loads on start, loses one bit per push
  // start and push never coincide, a start needs pending empty
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pending_mask <= '0;
      cmd_push     <= 1'b0;
    end else begin
      cmd_push <= push_ok;
      if (start_ok) begin
        pending_mask <= tap_to_upd;
      end else if (push_ok) begin
        pending_mask <= pending_mask & ~sel_bit;
      end
    end
  end

  // command word registered alongside cmd_push
  always_ff @(posedge clk) begin
    if (push_ok) begin
      cmd_addr <= sel_addr;
      cmd_data <= sel_data;
    end
  end

  // ========================================
  // credit counter
  // ========================================

  // spend on push, refund on completed write
  // both in one cycle leaves the count as is
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      credit_cnt <= credit_width'(cmd_fifo_depth);
    end else begin
      case ({push_ok, credit_return})
        2'b10:   credit_cnt <= credit_cnt - credit_width'(1);
        2'b01:   credit_cnt <= credit_cnt + credit_width'(1);
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

// File: hw/txeq_pkg.sv
// tx equalization tap widths, tap mask bit positions and tap register addresses

package txeq_pkg;

  // ========================================
  // tap value widths
  // ========================================

  // main cursor, unsigned magnitude from the training engine
  localparam int main_tap_width = 6;

  // first post cursor
  localparam int post_tap_width = 6;

  // pre cursor is one bit narrower on this transceiver
  localparam int pre_tap_width = 5;

  // ========================================
  // tap update mask
  // ========================================

  // one bit per tap, set bits are the taps to rewrite
  localparam int tap_mask_width = 3;

  // bit positions inside tap_to_upd
  // the highest bit goes out first
  localparam int main_tap_bit = 2;
  localparam int post_tap_bit = 1;
  localparam int pre_tap_bit  = 0;

  // ========================================
  // transceiver register map
  // ========================================

  // pma tx equalization registers on the reconfiguration port
  // each tap sits in its own 8-bit register, value in the low bits
  localparam logic [9:0] main_tap_addr = 10'h105;
  localparam logic [9:0] post_tap_addr = 10'h106;
  localparam logic [9:0] pre_tap_addr  = 10'h107;

  // upper register bits are written as zero
  // no read-modify-write is done on these registers

endpackage

// File: hw/txeq_reconfig_top.sv
// tx equalization reconfiguration top level with controller, command queue and write master

`timescale 1ns/1ns

module txeq_reconfig_top
  import avmm_pkg::*;
  import txeq_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  // link training engine side
  input  logic                       lt_start_rc,
  input  logic [main_tap_width-1:0]  main_rc,
  input  logic [post_tap_width-1:0]  post_rc,
  input  logic [pre_tap_width-1:0]   pre_rc,
  input  logic [tap_mask_width-1:0]  tap_to_upd,
  output logic                       rc_busy,
  // transceiver reconfiguration port
  output logic [rcfg_addr_width-1:0] rcfg_address,
  output logic [rcfg_data_width-1:0] rcfg_writedata,
  output logic                       rcfg_write,
  input  logic                       rcfg_waitrequest
);

  // ========================================
  // internal wiring
  // ========================================

  // controller to queue
  logic                       cmd_push;
  logic [rcfg_addr_width-1:0] push_addr;
  logic [rcfg_data_width-1:0] push_data;

  // queue to master
  logic                       cmd_valid;
  logic                       cmd_pop;
  logic [rcfg_addr_width-1:0] head_addr;
  logic [rcfg_data_width-1:0] head_data;

  // master to controller
  logic                       credit_return;

  // sequencer and credit keeper
  txeq_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .lt_start_rc   (lt_start_rc),
    .main_rc       (main_rc),
    .post_rc       (post_rc),
    .pre_rc        (pre_rc),
    .tap_to_upd    (tap_to_upd),
    .rc_busy       (rc_busy),
    .credit_return (credit_return),
    .cmd_push      (cmd_push),
    .cmd_addr      (push_addr),
    .cmd_data      (push_data)
  );

  // command queue, sized to the credit pool
  avmm_cmd_fifo u_cmd_fifo (
    .clk       (clk),
    .reset     (reset),
    .cmd_push  (cmd_push),
    .push_addr (push_addr),
    .push_data (push_data),
    .cmd_pop   (cmd_pop),
    .cmd_valid (cmd_valid),
    .cmd_addr  (head_addr),
    .cmd_data  (head_data)
  );

  // bus side
  avmm_write_master u_write_master (
    .clk              (clk),
    .reset            (reset),
    .cmd_valid        (cmd_valid),
    .cmd_addr         (head_addr),
    .cmd_data         (head_data),
    .cmd_pop          (cmd_pop),
    .rcfg_address     (rcfg_address),
    .rcfg_writedata   (rcfg_writedata),
    .rcfg_write       (rcfg_write),
    .rcfg_waitrequest (rcfg_waitrequest),
    .credit_return    (credit_return)
  );

endmodule

// File: src.f
hw/avmm_pkg.sv
hw/txeq_pkg.sv
hw/txeq_ctrl.sv
hw/avmm_cmd_fifo.sv
hw/avmm_write_master.sv
hw/txeq_reconfig_top.sv
verif/tb_txeq_reconfig.sv

// File: verif/tb_txeq_reconfig.sv
// testbench for the tx equalization reconfiguration top with file stimulus, bus responder and checks

`timescale 1ns/1ns

module tb_txeq_reconfig;

  // ========================================
  // constants
  // ========================================

  // tap register map of the transceiver
  localparam logic [9:0] exp_main_addr = 10'h105;
  localparam logic [9:0] exp_post_addr = 10'h106;
  localparam logic [9:0] exp_pre_addr  = 10'h107;

  // stimulus layout, five hex fields per test
  localparam int max_tests = 32;
  localparam int fields    = 5;

  // longest run of wait request the responder allows
  localparam int stretch_limit = 7;

  // run budget, per write cycles plus fixed slack
  localparam int writes_per_test  = 3;
  localparam int cycles_per_write = 12;
  localparam int slack_cycles     = 100;

  logic        clk = 1'b0;
  logic        reset;
  logic        lt_start_rc;
  logic [5:0]  main_rc;
  logic [5:0]  post_rc;
  logic [4:0]  pre_rc;
  logic [2:0]  tap_to_upd;
  logic        rc_busy;
  logic [9:0]  rcfg_address;
  logic [7:0]  rcfg_writedata;
  logic        rcfg_write;
  logic        rcfg_waitrequest;

  logic [7:0]  stim_mem [0:max_tests*fields-1];
  // writes as {address, data}
  logic [17:0] exp_q [$];
  logic [17:0] seen_q [$];

  // responder and hold tracking
  logic [31:0] lfsr;
  int          hi_run;
  logic        hold_active;
  logic [9:0]  held_addr;
  logic [7:0]  held_data;
  logic        rnd_b0;
  logic        rnd_b1;

  int          error_count;
  int          pass_count;
  int          fail_count;
  int          num_tests;
  int          cycle_count;
  int          cycle_limit;

  txeq_reconfig_top u_dut (
    .clk              (clk),
    .reset            (reset),
    .lt_start_rc      (lt_start_rc),
    .main_rc          (main_rc),
    .post_rc          (post_rc),
    .pre_rc           (pre_rc),
    .tap_to_upd       (tap_to_upd),
    .rc_busy          (rc_busy),
    .rcfg_address     (rcfg_address),
    .rcfg_writedata   (rcfg_writedata),
    .rcfg_write       (rcfg_write),
    .rcfg_waitrequest (rcfg_waitrequest)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // ========================================
  // helpers
  // ========================================

  // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;
    end
    return n;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("error: time %0t, %s expected %0h, actual %0h", $time, name, expected, actual);
    error_count++;
  endtask

  task automatic report_problem(input string what);
    $display("time %0t: %s", $time, what);
    error_count++;
  endtask

  // expected writes, order main post pre, data zero-extended to 8 bits
  task automatic build_expected(input logic [5:0] m, input logic [5:0] p,
                                input logic [4:0] r, input logic [2:0] k);
    exp_q.delete();
    if (k[2]) begin
      exp_q.push_back({exp_main_addr, 2'b00, m});
    end
    if (k[1]) begin
      exp_q.push_back({exp_post_addr, 2'b00, p});
    end
    if (k[0]) begin
      exp_q.push_back({exp_pre_addr, 3'b000, r});
    end
  endtask

  // in-order compare of captured writes, then clear them
  task automatic compare_writes(input int idx);
    int n;
    int i;
    n = (exp_q.size() < seen_q.size()) ? exp_q.size() : seen_q.size();
    for (i = 0; i < n; i++) begin
      if (seen_q[i][17:8] !== exp_q[i][17:8]) begin
        report_mismatch("rcfg_address", exp_q[i][17:8], seen_q[i][17:8]);
      end
      if (seen_q[i][7:0] !== exp_q[i][7:0]) begin
        report_mismatch("rcfg_writedata", exp_q[i][7:0], seen_q[i][7:0]);
      end
    end
    if (seen_q.size() < exp_q.size()) begin
      report_problem($sformatf("test %0d is missing writes, saw %0d of %0d",
                               idx, seen_q.size(), exp_q.size()));
    end else if (seen_q.size() > exp_q.size()) begin
      report_problem($sformatf("test %0d has extra writes, saw %0d but expected %0d",
                               idx, seen_q.size(), exp_q.size()));
    end
    seen_q.delete();
  endtask

  // one request from the file, start pulse then wait for busy to drop
  task automatic run_request(input int idx);
    logic [5:0] m;
    logic [5:0] p;
    logic [4:0] r;
    logic [2:0] k;
    logic       rpt;
    int         errs_before;
    m   = stim_mem[idx*fields][5:0];
    p   = stim_mem[idx*fields+1][5:0];
    r   = stim_mem[idx*fields+2][4:0];
    k   = stim_mem[idx*fields+3][2:0];
    rpt = stim_mem[idx*fields+4][0];
    errs_before = error_count;
    build_expected(m, p, r, k);
    @(negedge clk);
    main_rc     = m;
    post_rc     = p;
    pre_rc      = r;
    tap_to_upd  = k;
    lt_start_rc = 1'b1;
    @(negedge clk);
    lt_start_rc = 1'b0;
    if (k != 3'b000) begin
      if (rc_busy !== 1'b1) begin
        report_mismatch("rc_busy", 1, rc_busy);
      end
      // second start with other values, must be ignored
      if (rpt) begin
        main_rc     = ~m;
        post_rc     = ~p;
        pre_rc      = ~r;
        tap_to_upd  = 3'b111;
        lt_start_rc = 1'b1;
        @(negedge clk);
        lt_start_rc = 1'b0;
      end
      while (rc_busy === 1'b1) begin
        @(negedge clk);
      end
      // idle gap before the next start
      @(negedge clk);
      if (rc_busy !== 1'b0) begin
        report_mismatch("rc_busy", 0, rc_busy);
      end
    end else begin
      // empty mask, busy must never rise
      repeat (6) begin
        if (rc_busy !== 1'b0) begin
          report_mismatch("rc_busy", 0, rc_busy);
        end
        @(negedge clk);
      end
    end
    compare_writes(idx);
    if (error_count == errs_before) begin
      pass_count++;
      $display("test %0d main %h post %h pre %h mask %b repeat %0d: pass", idx, m, p, r, k, rpt);
    end else begin
      fail_count++;
      $display("test %0d main %h post %h pre %h mask %b repeat %0d: FAIL", idx, m, p, r, k, rpt);
    end
  endtask

  // ========================================
  // bus monitor and wait request responder
  // ========================================

  // check the hold from the last cycle, drive this cycle's wait request,
  // then judge the write against the edge that ends this cycle
  always @(negedge clk) begin
    if (hold_active) begin
      if (rcfg_write !== 1'b1) begin
        report_problem("write strobe dropped while waitrequest was high");
      end
      if (rcfg_address !== held_addr) begin
        report_mismatch("rcfg_address", held_addr, rcfg_address);
      end
      if (rcfg_writedata !== held_data) begin
        report_mismatch("rcfg_writedata", held_data, rcfg_writedata);
      end
    end
    if (hi_run >= stretch_limit) begin
      rcfg_waitrequest = 1'b0;
      hi_run = 0;
    end else begin
      // two bits, stall unless both are zero
      rnd_b0 = lfsr[0];
      lfsr   = lfsr_step(lfsr);
      rnd_b1 = lfsr[0];
      lfsr   = lfsr_step(lfsr);
      rcfg_waitrequest = rnd_b0 | rnd_b1;
      hi_run = rcfg_waitrequest ? hi_run + 1 : 0;
    end
    // write lands at the next rising edge
    if (rcfg_write === 1'b1 && rcfg_waitrequest === 1'b0) begin
      seen_q.push_back({rcfg_address, rcfg_writedata});
      if (rc_busy !== 1'b1) begin
        report_problem("write completed while rc_busy was low");
      end
    end
    hold_active = (rcfg_write === 1'b1) && (rcfg_waitrequest === 1'b1);
    held_addr   = rcfg_address;
    held_data   = rcfg_writedata;
  end

  // run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, the request never finished", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  // ========================================
  // main sequence
  // ========================================

  initial begin
    int errs;
    int t;
    reset = 1'b1;
    lt_start_rc = 1'b0;
    main_rc = '0;
    post_rc = '0;
    pre_rc = '0;
    tap_to_upd = '0;
    rcfg_waitrequest = 1'b0;
    lfsr = 32'h99522d79;
    hi_run = 0;
    hold_active = 1'b0;
    held_addr = '0;
    held_data = '0;
    error_count = 0;
    pass_count = 0;
    fail_count = 0;
    cycle_count = 0;
    $readmemh("verif/txeq_input.txt", stim_mem);
    num_tests = 0;
    while (num_tests < max_tests && !$isunknown(stim_mem[num_tests*fields])) begin
      num_tests++;
    end
    cycle_limit = num_tests * writes_per_test * cycles_per_write + slack_cycles;
    if (num_tests == 0) begin
      report_problem("no tests found in verif/txeq_input.txt");
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // quiet bus and idle busy before any start
    errs = error_count;
    repeat (6) begin
      @(negedge clk);
      if (rcfg_write !== 1'b0) begin
        report_mismatch("rcfg_write", 0, rcfg_write);
      end
      if (rc_busy !== 1'b0) begin
        report_mismatch("rc_busy", 0, rc_busy);
      end
    end
    if (error_count == errs) begin
      pass_count++;
      $display("test idle after reset: pass");
    end else begin
      fail_count++;
      $display("test idle after reset: FAIL");
    end
    for (t = 0; t < num_tests; t++) begin
      run_request(t);
    end
    $display("tests run %0d, passed %0d, failed %0d", pass_count + fail_count,
             pass_count, fail_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verif/txeq_input.txt
// columns: main post pre mask repeat, all hex, one test per line
// main and post are 6 bits, pre is 5 bits, mask bits are main post pre, repeat is 0 or 1
2a 00 00 4 0
00 15 00 2 0
00 00 0b 1 0
3f 3f 1f 7 0
00 00 00 7 0
11 22 0c 7 0
05 3a 1e 0 0
19 07 13 6 0
0e 2d 04 5 0
30 01 1a 3 0
21 12 09 7 1
3c 00 10 4 1
00 2f 00 2 1
08 08 08 0 0
1b 36 15 7 0
3f 00 1f 5 1
01 02 03 7 0
2e 1d 0f 3 1
14 28 11 7 1
37 0a 02 6 0
06 3e 1c 0 1
